/* hw/game_settings.svh */
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Field edges in pixels.
`define LEFT_BOUND  20
`define RIGHT_BOUND 320
`define UP_BOUND    40
`define FLOOR_Y     240

// Every new ball appears at this x.
`define START_X     170

`define FALL_STEP   3       // Pixels fallen per cycle.

`define NUM_SLOTS   10      // One slot per ball in a game.

// Ball radii in pixels.
`define SIZE_1      5
`define SIZE_2      10
`define SIZE_3      15
`define SIZE_4      20

`define COORD_W     12      // Width of x, y and size.

`endif

/* hw/game_geom_pkg.sv */
`default_nettype none

`include "game_settings.svh"

package game_geom_pkg;

    // Unsigned pixel value, used for x, y and ball size alike.
    typedef logic [`COORD_W-1:0] coord_t;

    // Record of one landed ball.
    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t size;       // Radius in pixels.
    } ball_t;

endpackage

`default_nettype wire

/* hw/game_ctrl_pkg.sv */
`default_nettype none

`include "game_settings.svh"

package game_ctrl_pkg;

    typedef enum logic [1:0] {
        phase_aim,          // Ball moves along the top edge.
        phase_fall,
        phase_land,         // Landing record offered, waiting for ready.
        phase_over
    } phase_t;

    typedef logic [$clog2(`NUM_SLOTS)-1:0] slot_t;

endpackage

`default_nettype wire

/* hw/landing_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One landing write into the slot store; place is the write strobe.
interface landing_if
    import game_geom_pkg::*, game_ctrl_pkg::*;
();

    logic   place;
    slot_t  slot;
    coord_t x;
    coord_t y;
    coord_t size;

    modport fsm_mp (output place);

    modport seq_mp (input place, output slot, output size);

    modport mover_mp (input place, input size, output x, output y);

    modport store_mp (input place, input slot, input x, input y, input size);

endinterface

`default_nettype wire

/* hw/drop_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module drop_fsm
    import game_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       drop,
    input  logic       at_floor,
    input  logic       all_placed,
    input  logic       land_ready,
    output phase_t     phase,
    output logic       land_valid,
    output logic       game_over,
    landing_if.fsm_mp  lnd
);

    phase_t phase_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phase_aim;
        end else begin
            phase <= phase_next;
        end
    end

    always_comb begin
        phase_next = phase;
        unique case (phase)
            phase_aim: begin
                if (drop) begin
                    phase_next = phase_fall;
                end
            end
            phase_fall: begin
                if (at_floor) begin
                    phase_next = phase_land;
                end
            end
            phase_land: begin
                if (land_ready) begin  // Held here while the sink stalls.
                    phase_next = all_placed ? phase_over : phase_aim;
                end
            end
            phase_over: begin
                phase_next = phase_over;  // Only reset leaves this state.
            end
            default: begin
                phase_next = phase_aim;
            end
        endcase
    end

    assign land_valid = (phase == phase_land);
    assign game_over  = (phase == phase_over);

    // A write happens exactly when the landing record transfers.
    assign lnd.place = land_valid && land_ready;

endmodule

`default_nettype wire

/* hw/ball_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module ball_sequencer
    import game_geom_pkg::*, game_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    landing_if.seq_mp  lnd,
    output logic       all_placed
);

    // Ball radius for each slot, in drop order.
    localparam coord_t SIZE_SEQ [`NUM_SLOTS] = '{
        coord_t'(`SIZE_3), coord_t'(`SIZE_2), coord_t'(`SIZE_1), coord_t'(`SIZE_4),
        coord_t'(`SIZE_2), coord_t'(`SIZE_3), coord_t'(`SIZE_1), coord_t'(`SIZE_3),
        coord_t'(`SIZE_1), coord_t'(`SIZE_1)
    };

    localparam slot_t LAST_SLOT = slot_t'(`NUM_SLOTS - 1);

    slot_t count;   // Balls placed so far, also the slot of the current ball.

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (lnd.place && count <= LAST_SLOT) begin
            count <= count + 1'b1;
        end
    end

    assign lnd.slot = count;

    // No ball is left once every slot is used.
    assign lnd.size = (count <= LAST_SLOT) ? SIZE_SEQ[count] : '0;

    // The pending place is the one for the last slot.
    assign all_placed = (count == LAST_SLOT);

endmodule

`default_nettype wire

/* hw/ball_mover.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module ball_mover
    import game_geom_pkg::*, game_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         left,
    input  logic         right,
    input  phase_t       phase,
    landing_if.mover_mp  lnd,
    output logic         at_floor,
    output coord_t       aim_x
);

    coord_t x;
    coord_t y;
    coord_t x_min;
    coord_t x_max;
    coord_t y_top;
    coord_t y_floor;
    coord_t y_step;

    // The ball must stay fully inside the field, so every limit depends on its size.
    assign x_min   = coord_t'(`LEFT_BOUND) + lnd.size;
    assign x_max   = coord_t'(`RIGHT_BOUND) - lnd.size;
    assign y_top   = coord_t'(`UP_BOUND) - lnd.size;
    assign y_floor = coord_t'(`FLOOR_Y) - lnd.size;
    assign y_step  = y + coord_t'(`FALL_STEP);

    always_ff @(posedge clk) begin
        if (rst) begin
            x <= coord_t'(`START_X);
            y <= y_top;
        end else begin
            unique case (phase)
                phase_aim: begin
                    y <= y_top;
                    if (left) begin  // Left wins when both are pressed.
                        if (x > x_min) begin
                            x <= x - 1'b1;
                        end
                    end else if (right) begin
                        if (x < x_max) begin
                            x <= x + 1'b1;
                        end
                    end
                end
                phase_fall: begin
                    y <= (y_step >= y_floor) ? y_floor : y_step;  // Last step is clamped.
                end
                phase_land: begin
                    if (lnd.place) begin
                        x <= coord_t'(`START_X);  // Next ball starts in the middle.
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign at_floor = (phase == phase_fall) && (y == y_floor);

    assign lnd.x = x;
    assign lnd.y = y;
    assign aim_x = x;

endmodule

`default_nettype wire

/* hw/slot_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module slot_store
    import game_geom_pkg::*, game_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    landing_if.store_mp  lnd,
    input  slot_t        rd_slot,
    output ball_t        rd_ball
);

    localparam slot_t LAST_SLOT = slot_t'(`NUM_SLOTS - 1);

    ball_t slots [`NUM_SLOTS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                slots[i] <= '0;  // Empty slots read as zero.
            end
        end else if (lnd.place && lnd.slot <= LAST_SLOT) begin
            slots[lnd.slot] <= '{x: lnd.x, y: lnd.y, size: lnd.size};
        end
    end

    // Indexes past the last slot read zero.
    assign rd_ball = (rd_slot <= LAST_SLOT) ? slots[rd_slot] : '0;

endmodule

`default_nettype wire

/* hw/ball_drop_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ball_drop_top
    import game_geom_pkg::*, game_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   left,
    input  logic   right,
    input  logic   drop,
    input  logic   land_ready,
    input  slot_t  rd_slot,
    output logic   land_valid,
    output logic   game_over,
    output slot_t  land_slot,
    output coord_t land_x,
    output coord_t land_y,
    output coord_t land_size,
    output coord_t aim_x,
    output coord_t rd_x,
    output coord_t rd_y,
    output coord_t rd_size
);

    phase_t phase;
    logic   at_floor;
    logic   all_placed;
    ball_t  rd_ball;

    landing_if lnd ();

    drop_fsm drop_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .drop       (drop),
        .at_floor   (at_floor),
        .all_placed (all_placed),
        .land_ready (land_ready),
        .phase      (phase),
        .land_valid (land_valid),
        .game_over  (game_over),
        .lnd        (lnd.fsm_mp)
    );

    ball_sequencer ball_sequencer_i (
        .clk        (clk),
        .rst        (rst),
        .lnd        (lnd.seq_mp),
        .all_placed (all_placed)
    );

    ball_mover ball_mover_i (
        .clk      (clk),
        .rst      (rst),
        .left     (left),
        .right    (right),
        .phase    (phase),
        .lnd      (lnd.mover_mp),
        .at_floor (at_floor),
        .aim_x    (aim_x)
    );

    slot_store slot_store_i (
        .clk     (clk),
        .rst     (rst),
        .lnd     (lnd.store_mp),
        .rd_slot (rd_slot),
        .rd_ball (rd_ball)
    );

    // The landing record is the pending slot write.
    assign land_slot = lnd.slot;
    assign land_x    = lnd.x;
    assign land_y    = lnd.y;
    assign land_size = lnd.size;

    assign rd_x    = rd_ball.x;
    assign rd_y    = rd_ball.y;
    assign rd_size = rd_ball.size;

endmodule

`default_nettype wire

/* tests/ball_drop_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module ball_drop_props
    import game_geom_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   land_valid,
    input logic   land_ready,
    input logic   game_over,
    input coord_t land_x,
    input coord_t land_y,
    input coord_t land_size,
    input coord_t aim_x
);

    int unsigned fail_count = 0;  // Number of assertion failures so far.

    // A stalled landing record holds until the sink takes it.
    stall_holds: assert property (@(posedge clk) disable iff (rst)
        land_valid && !land_ready |=> land_valid && $stable(land_x) && $stable(land_y))
        else begin
            fail_count++;
            $error("landing record changed while land_ready was low");
        end

    // Once over, the game stays over and never offers another landing.
    over_excludes_land: assert property (@(posedge clk) disable iff (rst)
        game_over |=> game_over && !land_valid)
        else begin
            fail_count++;
            $error("game_over dropped or land_valid rose after game over");
        end

    // The ball stays fully inside the field.
    aim_in_bounds: assert property (@(posedge clk) disable iff (rst)
        aim_x >= coord_t'(`LEFT_BOUND) + land_size && aim_x <= coord_t'(`RIGHT_BOUND) - land_size)
        else begin
            fail_count++;
            $error("aim_x outside the size-dependent bounds");
        end

endmodule

bind ball_drop_top ball_drop_props props_i (
    .clk        (clk),
    .rst        (rst),
    .land_valid (land_valid),
    .land_ready (land_ready),
    .game_over  (game_over),
    .land_x     (land_x),
    .land_y     (land_y),
    .land_size  (land_size),
    .aim_x      (aim_x)
);

`default_nettype wire

/* tests/ball_drop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "game_settings.svh"

module ball_drop_tb
    import game_geom_pkg::*, game_ctrl_pkg::*;
();

    logic   clk;
    logic   rst;
    logic   left;
    logic   right;
    logic   drop;
    logic   land_ready;
    slot_t  rd_slot;
    logic   land_valid;
    logic   game_over;
    slot_t  land_slot;
    coord_t land_x;
    coord_t land_y;
    coord_t land_size;
    coord_t aim_x;
    coord_t rd_x;
    coord_t rd_y;
    coord_t rd_size;

    int t_moves[$];
    int t_stalls[$];
    int t_x[$];
    int t_y[$];
    int t_size[$];
    int t_slot[$];

    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_errors_at_start = 0;
    string test_name;
    int    cycle_limit = 0;
    int    cycles = 0;

    ball_drop_top ball_drop_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors != test_errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", test_name,
                     errors - test_errors_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        int    mv;
        int    st;
        int    ex;
        int    ey;
        int    es;
        int    esl;
        string line;
        fd = $fopen("tests/ball_drop_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the trace file tests/ball_drop_trace.txt.");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d", mv, st, ex, ey, es, esl);
                    if (n == 6) begin
                        t_moves.push_back(mv);
                        t_stalls.push_back(st);
                        t_x.push_back(ex);
                        t_y.push_back(ey);
                        t_size.push_back(es);
                        t_slot.push_back(esl);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Aim, drop, then hold the landing for the stall cycles before taking it.
    task automatic run_ball(input int b);
        int     steps;
        coord_t held_x;
        coord_t held_y;
        coord_t held_size;
        slot_t  held_slot;
        steps = (t_moves[b] < 0) ? -t_moves[b] : t_moves[b];
        repeat (steps) begin
            @(posedge clk);
            left  <= (t_moves[b] < 0);
            right <= (t_moves[b] > 0);
        end
        @(posedge clk);
        left  <= 1'b0;
        right <= 1'b0;
        @(negedge clk);
        check_value(32'(aim_x), t_x[b], "aim_x after aiming");
        @(posedge clk);
        drop <= 1'b1;
        @(posedge clk);
        drop <= 1'b0;
        @(negedge clk);
        while (!land_valid) begin
            @(negedge clk);
        end
        check_value(32'(land_x), t_x[b], "land_x");
        check_value(32'(land_y), t_y[b], "land_y");
        check_value(32'(land_size), t_size[b], "land_size");
        check_value(32'(land_slot), t_slot[b], "land_slot");
        held_x    = land_x;
        held_y    = land_y;
        held_size = land_size;
        held_slot = land_slot;
        repeat (t_stalls[b]) begin
            @(posedge clk);
            @(negedge clk);
            check_value(32'(land_valid), 1, "land_valid during stall");
            check_value(32'(land_x), 32'(held_x), "land_x during stall");
            check_value(32'(land_y), 32'(held_y), "land_y during stall");
            check_value(32'(land_size), 32'(held_size), "land_size during stall");
            check_value(32'(land_slot), 32'(held_slot), "land_slot during stall");
        end
        @(posedge clk);
        land_ready <= 1'b1;
        @(posedge clk);
        land_ready <= 1'b0;
        @(negedge clk);
        check_value(32'(land_valid), 0, "land_valid after transfer");
        check_value(32'(aim_x), `START_X, "aim_x after transfer");
    endtask

    initial begin
        rst        = 1'b1;
        left       = 1'b0;
        right      = 1'b0;
        drop       = 1'b0;
        land_ready = 1'b0;
        rd_slot    = '0;
        load_trace();
        cycle_limit = 100;
        for (int i = 0; i < t_moves.size(); i++) begin
            cycle_limit += ((t_moves[i] < 0) ? -t_moves[i] : t_moves[i]) + t_stalls[i] + 75;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        if (t_moves.size() != `NUM_SLOTS) begin
            errors++;
            $display("The trace holds %0d balls, but the game needs %0d.",
                     t_moves.size(), `NUM_SLOTS);
        end else begin
            begin_test("reset");
            check_value(32'(land_valid), 0, "land_valid after reset");
            check_value(32'(game_over), 0, "game_over after reset");
            check_value(32'(aim_x), `START_X, "aim_x after reset");
            check_value(32'(land_y), `UP_BOUND - t_size[0], "ball y after reset");
            finish_test();

            for (int b = 0; b < `NUM_SLOTS; b++) begin
                begin_test($sformatf("ball %0d", b));
                run_ball(b);
                finish_test();
            end

            begin_test("completion");
            check_value(32'(game_over), 1, "game_over after last transfer");
            @(posedge clk);
            drop  <= 1'b1;
            right <= 1'b1;
            repeat (8) begin
                @(posedge clk);
                @(negedge clk);
                check_value(32'(game_over), 1, "game_over with inputs held");
                check_value(32'(land_valid), 0, "land_valid in game over");
                check_value(32'(aim_x), `START_X, "aim_x in game over");
            end
            @(posedge clk);
            drop  <= 1'b0;
            right <= 1'b0;
            finish_test();

            begin_test("readback");
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                @(posedge clk);
                rd_slot <= slot_t'(i);
                @(negedge clk);
                check_value(32'(rd_x), t_x[i], $sformatf("rd_x of slot %0d", i));
                check_value(32'(rd_y), t_y[i], $sformatf("rd_y of slot %0d", i));
                check_value(32'(rd_size), t_size[i], $sformatf("rd_size of slot %0d", i));
            end
            @(posedge clk);
            rd_slot <= slot_t'(`NUM_SLOTS);  // Past the last slot.
            @(negedge clk);
            check_value(32'(rd_size), 0, "rd_size of an unused index");
            finish_test();
        end

        $display(
            "Summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d assertion failures",
            tests_run, tests_failed, checks, errors, ball_drop_top_i.props_i.fail_count);
        if (errors == 0 && ball_drop_top_i.props_i.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog on the cycle budget of the trace.
    initial begin
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/ball_drop_trace.txt */
# Columns: moves (negative = left cycles, positive = right cycles), stall cycles,
# then expected land_x, land_y, land_size and land_slot, all decimal.
-200 0  35 225 15 0
  10 3 180 230 10 1
 150 1 315 235  5 2
   0 5 170 220 20 3
 -30 0 140 230 10 4
 140 2 305 225 15 5
  -5 4 165 235  5 6
  25 0 195 225 15 7
-160 1  25 235  5 8
   3 2 173 235  5 9

/* ball_drop.f */
+incdir+hw
hw/game_geom_pkg.sv
hw/game_ctrl_pkg.sv
hw/landing_if.sv
hw/drop_fsm.sv
hw/ball_sequencer.sv
hw/ball_mover.sv
hw/slot_store.sv
hw/ball_drop_top.sv
tests/ball_drop_props.sv
tests/ball_drop_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := ball_drop_tb
DUT_TOP    := ball_drop_top
FILELIST   := ball_drop.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := \*\*\* PASSED \*\*\*

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
